//--- run_sim.sh
#!/usr/bin/env bash
# build and run the auto-zero testbench with Verilator
# pass or fail is taken from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module azero_tb -Mdir "$BUILD_DIR" -o azero_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/azero_sim" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "No errors" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- source/az_result_unit.sv
/*
  pairs each HI conversion with the LO conversion that follows it
  result is overwritten on every completed pair, there is no back-pressure
  result_valid pulses one cycle after the LO capture strobe
  hi_phase follows the last capture, one cycle late
*/

`timescale 1ns/100ps

module az_result_unit (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       capture_hi_i,
  input  logic                       capture_lo_i,
  input  logic [azero_pkg::ADC_W-1:0] adc_count_i,
  output azero_pkg::az_result_t      result_o,
  output logic                       result_valid_o,
  output logic                       hi_phase_o
);

  import azero_pkg::*;

  // hi count waits here until its lo partner arrives
  logic [ADC_W-1:0]         hi_hold_q;
  az_result_t               result_q;
  logic                     result_valid_q;
  logic                     hi_phase_q;
  logic signed [DIFF_W-1:0] diff_d;

  // both counts are unsigned, zero extend before subtracting
  assign diff_d = $signed({1'b0, hi_hold_q}) - $signed({1'b0, adc_count_i});

  ////////////////////////////////////////////////////////////
  // payload, no reset needed

  always_ff @(posedge clk)
  begin
    if (capture_hi_i)
    begin
      hi_hold_q <= adc_count_i;
    end
    if (capture_lo_i)
    begin
      result_q.hi_count <= hi_hold_q;
      result_q.lo_count <= adc_count_i;
      result_q.diff     <= diff_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // status and valid strobe

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      result_valid_q <= 1'b0;
      hi_phase_q     <= 1'b0;
    end
    else
    begin
      // single cycle pulse per completed pair
      result_valid_q <= capture_lo_i;
      // status only moves after a conversion, so it stays stable during readout
      if (capture_hi_i)
        hi_phase_q <= 1'b1;
      else if (capture_lo_i)
        hi_phase_q <= 1'b0;
    end
  end

  assign result_o       = result_q;
  assign result_valid_o = result_valid_q;
  assign hi_phase_o     = hi_phase_q;

endmodule

//--- source/az_sequencer.sv
/*
  auto-zero acquisition control, alternates HI and LO measurements forever
  every switch change is followed by a precharge_count settle via the timer
  the ADC is expected to hold valid high until its reset is driven low again
  adc reset rises precharge_count+2 cycles after the last switch change
*/

`timescale 1ns/100ps

module az_sequencer (
  input  logic                         clk,
  input  logic                         reset_n,
  input  azero_pkg::az_cfg_t           cfg_i,
  input  logic                         adc_valid_i,
  input  logic                         timer_done_i,
  output logic                         timer_load_o,
  output logic [azero_pkg::COUNT_W-1:0] timer_count_o,
  output azero_pkg::az_switch_t        switch_o,
  output logic                         adc_reset_n_o,
  output logic                         capture_hi_o,
  output logic                         capture_lo_o
);

  import azero_pkg::*;

  // one step state per switch change, each followed by its settle wait
  typedef enum logic [3:0] {
    ST_BOOT_STEP,
    ST_BOOT_WAIT,
    ST_HI_MUX_STEP,
    ST_HI_MUX_WAIT,
    ST_HI_PC_STEP,
    ST_HI_PC_WAIT,
    ST_HI_MEAS,
    ST_LO_PC_STEP,
    ST_LO_PC_WAIT,
    ST_LO_MUX_STEP,
    ST_LO_MUX_WAIT,
    ST_LO_MEAS
  } seq_state_t;

  seq_state_t  state_q;
  az_switch_t  switch_q;
  logic        adc_reset_n_q;

  ////////////////////////////////////////////////////////////
  // state register and switch drive
  // switches are updated on entry to a step state, so the settle
  // count starts in the same cycle as the new switch position

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_q        <= ST_BOOT_STEP;
      // protect position, mux parked on lo
      switch_q.sw_pc <= SW_PC_BOOT;
      switch_q.azmux <= cfg_i.azmux_lo;
      adc_reset_n_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        ST_BOOT_STEP:
          state_q <= ST_BOOT_WAIT;
        ST_BOOT_WAIT:
          if (timer_done_i)
          begin
            state_q        <= ST_HI_MUX_STEP;
            switch_q.azmux <= cfg_i.azmux_hi;
          end
        // hi precharge, signal still behind the boot switch
        ST_HI_MUX_STEP:
          state_q <= ST_HI_MUX_WAIT;
        ST_HI_MUX_WAIT:
          if (timer_done_i)
          begin
            state_q        <= ST_HI_PC_STEP;
            switch_q.sw_pc <= cfg_i.pc_hi;
          end
        // short settle for the sig/boot offset before converting
        ST_HI_PC_STEP:
          state_q <= ST_HI_PC_WAIT;
        ST_HI_PC_WAIT:
          if (timer_done_i)
          begin
            state_q       <= ST_HI_MEAS;
            // release the adc
            adc_reset_n_q <= 1'b1;
          end
        ST_HI_MEAS:
          if (adc_valid_i)
          begin
            state_q        <= ST_LO_PC_STEP;
            adc_reset_n_q  <= 1'b0;
            // back to protect before the mux moves
            switch_q.sw_pc <= SW_PC_BOOT;
          end
        ST_LO_PC_STEP:
          state_q <= ST_LO_PC_WAIT;
        ST_LO_PC_WAIT:
          if (timer_done_i)
          begin
            state_q        <= ST_LO_MUX_STEP;
            switch_q.azmux <= cfg_i.azmux_lo;
          end
        ST_LO_MUX_STEP:
          state_q <= ST_LO_MUX_WAIT;
        ST_LO_MUX_WAIT:
          if (timer_done_i)
          begin
            state_q       <= ST_LO_MEAS;
            adc_reset_n_q <= 1'b1;
          end
        ST_LO_MEAS:
          if (adc_valid_i)
          begin
            // pair complete, restart at the hi precharge
            state_q        <= ST_HI_MUX_STEP;
            adc_reset_n_q  <= 1'b0;
            switch_q.azmux <= cfg_i.azmux_hi;
          end
        default:
          state_q <= ST_BOOT_STEP;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // timer control and capture strobes

  // every step state starts a fresh settle phase
  assign timer_load_o = (state_q == ST_BOOT_STEP)   || (state_q == ST_HI_MUX_STEP) ||
                        (state_q == ST_HI_PC_STEP)  || (state_q == ST_LO_PC_STEP)  ||
                        (state_q == ST_LO_MUX_STEP);
  assign timer_count_o = cfg_i.precharge_count;

  // one cycle wide, the state moves on in the same cycle
  assign capture_hi_o = (state_q == ST_HI_MEAS) && adc_valid_i;
  assign capture_lo_o = (state_q == ST_LO_MEAS) && adc_valid_i;

  assign switch_o      = switch_q;
  assign adc_reset_n_o = adc_reset_n_q;

endmodule

//--- source/azero_pkg.sv
/*
  shared widths, switch codes and packed structs for the auto-zero sequencer
  the configuration struct is expected to be held static while a run is active
  counts are unsigned ADC codes, the corrected diff is signed and one bit wider
*/

package azero_pkg;

  ////////////////////////////////////////////////////////////
  // widths

  // settle count per phase, in clk cycles
  localparam int COUNT_W = 24;
  // raw ADC conversion count
  localparam int ADC_W   = 24;
  // auto-zero mux select
  localparam int AZMUX_W = 4;
  // precharge switch control
  localparam int PC_W    = 2;
  // hi minus lo needs one extra bit for the sign
  localparam int DIFF_W  = ADC_W + 1;

  ////////////////////////////////////////////////////////////
  // switch codes

  // boot position, keeps the signal protected from az mux charge injection
  localparam logic [PC_W-1:0] SW_PC_BOOT = 2'b00;

  ////////////////////////////////////////////////////////////
  // structs

  // static configuration, 34 bits
  typedef struct packed {
    logic [COUNT_W-1:0] precharge_count;
    logic [AZMUX_W-1:0] azmux_hi;
    logic [AZMUX_W-1:0] azmux_lo;
    logic [PC_W-1:0]    pc_hi;
  } az_cfg_t;

  // switch drive towards the analog front end, 6 bits
  typedef struct packed {
    logic [AZMUX_W-1:0] azmux;
    logic [PC_W-1:0]    sw_pc;
  } az_switch_t;

  // one offset-corrected result, 73 bits
  typedef struct packed {
    logic [ADC_W-1:0]         hi_count;
    logic [ADC_W-1:0]         lo_count;
    logic signed [DIFF_W-1:0] diff;
  } az_result_t;

endpackage

//--- source/azero_top.sv
/*
  auto-zero acquisition top level
  cfg_i must stay constant while the sequencer runs
  adc_valid_i is a level, held by the ADC until adc_reset_n_o falls
*/

`timescale 1ns/100ps

module azero_top (
  input  logic                       clk,
  input  logic                       reset_n,
  input  azero_pkg::az_cfg_t         cfg_i,
  input  logic                       adc_valid_i,
  input  logic [azero_pkg::ADC_W-1:0] adc_count_i,
  output azero_pkg::az_switch_t      switch_o,
  output logic                       adc_reset_n_o,
  output logic                       hi_phase_o,
  output azero_pkg::az_result_t      result_o,
  output logic                       result_valid_o
);

  import azero_pkg::*;

  // sequencer to timer
  logic               timer_load;
  logic [COUNT_W-1:0] timer_count;
  logic               timer_done;
  // sequencer to result unit
  logic               capture_hi;
  logic               capture_lo;

  az_sequencer i_seq (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_i         (cfg_i),
    .adc_valid_i   (adc_valid_i),
    .timer_done_i  (timer_done),
    .timer_load_o  (timer_load),
    .timer_count_o (timer_count),
    .switch_o      (switch_o),
    .adc_reset_n_o (adc_reset_n_o),
    .capture_hi_o  (capture_hi),
    .capture_lo_o  (capture_lo)
  );

  phase_timer i_timer (
    .clk     (clk),
    .reset_n (reset_n),
    .load_i  (timer_load),
    .count_i (timer_count),
    .done_o  (timer_done)
  );

  az_result_unit i_result (
    .clk            (clk),
    .reset_n        (reset_n),
    .capture_hi_i   (capture_hi),
    .capture_lo_i   (capture_lo),
    .adc_count_i    (adc_count_i),
    .result_o       (result_o),
    .result_valid_o (result_valid_o),
    .hi_phase_o     (hi_phase_o)
  );

endmodule

//--- source/phase_timer.sv
/*
  count-down timer for the settle phases
  a load with N gives done N+1 cycles after the load cycle
  done is held low in any cycle that has load high
*/

`timescale 1ns/100ps

module phase_timer (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         load_i,
  input  logic [azero_pkg::COUNT_W-1:0] count_i,
  output logic                         done_o
);

  import azero_pkg::*;

  // remaining settle cycles, zero when idle
  logic [COUNT_W-1:0] count_q;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      count_q <= '0;
    end
    else if (load_i)
    begin
      // a new phase starts, take the full count
      count_q <= count_i;
    end
    else if (count_q != '0)
    begin
      count_q <= count_q - 1'b1;
    end
  end

  // expired only if no new phase is being loaded this cycle
  assign done_o = (count_q == '0) && !load_i;

endmodule

//--- test/azero_patterns.txt
// index precharge_count azmux_hi azmux_lo pc_hi hi_count lo_count expected_diff
// all hex, diff is hi minus lo as 25 bit two's complement, last line ends the list
00 05 4 3 1 000100 000080 0000080
01 00 4 3 1 123456 023456 0100000
02 01 5 3 2 000010 000020 1fffff0
03 0a 4 3 1 ffffff 000000 0ffffff
04 03 6 2 3 000000 ffffff 1000001
05 10 4 3 1 800000 7fffff 0000001
06 02 7 0 2 7fffff 800000 1ffffff
07 14 4 3 1 abcdef abcdef 0000000
08 07 1 8 3 00a000 005000 0005000
09 04 9 3 1 001234 004321 1ffcf13
0a 1f 4 3 2 400000 100000 0300000
0b 06 c 5 1 0f0f0f f0f0f0 11e1e1f
0c 28 4 3 3 fffffe ffffff 1ffffff
0d 02 2 1 1 000001 000000 0000001
0e 09 a b 2 5a5a5a 0a5a5a 0500000
0f 03 4 3 1 000000 000001 1ffffff
ffffffff

//--- test/azero_props.sv
/*
  switch ordering properties for az_sequencer, bound into every instance
  fail_count holds the number of property failures seen so far
*/

`timescale 1ns/100ps

module azero_props (
  input logic                  clk,
  input logic                  reset_n,
  input azero_pkg::az_switch_t switch_o,
  input logic                  adc_reset_n_o,
  input logic                  timer_load_o,
  input logic                  timer_done_i,
  input logic                  capture_hi_o,
  input logic                  capture_lo_o
);

  import azero_pkg::*;

  int unsigned fail_count = 0;

  // timer busy from the cycle after a load up to the cycle that reports done
  logic busy_q;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      busy_q <= 1'b0;
    else if (timer_load_o)
      busy_q <= 1'b1;
    else if (timer_done_i)
      busy_q <= 1'b0;
  end

  // the mux only moves while the signal sits behind the boot switch
  a_mux_behind_boot: assert property (@(posedge clk) disable iff (!reset_n)
    (switch_o.azmux != $past(switch_o.azmux)) |-> (switch_o.sw_pc == SW_PC_BOOT))
  else
  begin
    fail_count++;
    $error("azmux changed while sw_pc was not in the boot position");
  end

  // adc stays in reset for the whole settle phase
  a_release_after_settle: assert property (@(posedge clk) disable iff (!reset_n)
    busy_q |-> !adc_reset_n_o)
  else
  begin
    fail_count++;
    $error("adc reset released while the phase timer was still counting");
  end

  a_capture_hi_single: assert property (@(posedge clk) disable iff (!reset_n)
    capture_hi_o |=> !capture_hi_o)
  else
  begin
    fail_count++;
    $error("capture_hi strobe was longer than one cycle");
  end

  a_capture_lo_single: assert property (@(posedge clk) disable iff (!reset_n)
    capture_lo_o |=> !capture_lo_o)
  else
  begin
    fail_count++;
    $error("capture_lo strobe was longer than one cycle");
  end

endmodule

bind az_sequencer azero_props i_props (
  .clk           (clk),
  .reset_n       (reset_n),
  .switch_o      (switch_o),
  .adc_reset_n_o (adc_reset_n_o),
  .timer_load_o  (timer_load_o),
  .timer_done_i  (timer_done_i),
  .capture_hi_o  (capture_hi_o),
  .capture_lo_o  (capture_lo_o)
);

//--- test/azero_tb.sv
/*
  testbench for azero_top with a simple ADC model, run from the project root
  patterns come from test/azero_patterns.txt, one line per configuration
  every pattern gets its own reset and three HI/LO pairs
  assumes pc_hi is not the boot code and azmux_hi differs from azmux_lo
*/

`timescale 1ns/100ps

module azero_tb;

  import azero_pkg::*;

  localparam int PAT_WORDS  = 8;
  localparam int MAX_PAT    = 32;
  localparam int PAIRS      = 3;
  localparam int WAIT_LIMIT = 2000;
  localparam logic [31:0] END_MARK = 32'hffff_ffff;

  logic             clk = 1'b0;
  logic             reset_n;
  az_cfg_t          cfg_i;
  logic             adc_valid_i;
  logic [ADC_W-1:0] adc_count_i;
  az_switch_t       switch_o;
  logic             adc_reset_n_o;
  logic             hi_phase_o;
  az_result_t       result_o;
  logic             result_valid_o;

  // 8 words per pattern, then the end marker
  logic [31:0] pat_mem [PAT_WORDS*MAX_PAT+1];
  az_cfg_t     cur_cfg = '0;
  int          pat_idx = 0;
  bit          meas_hi = 1'b0;
  bit          monitor_on = 1'b0;
  bit          abort = 1'b0;
  int          value_errs = 0;
  int          timeout_errs = 0;
  int          other_errs = 0;
  // switch change tracking for the release delay
  int          cyc = 0;
  int          last_change_cyc = 0;
  az_switch_t  last_switch = '0;
  logic        prev_adc_rst = 1'b0;

  always #2 clk = ~clk;

  azero_top i_dut (
    .clk            (clk),
    .reset_n        (reset_n),
    .cfg_i          (cfg_i),
    .adc_valid_i    (adc_valid_i),
    .adc_count_i    (adc_count_i),
    .switch_o       (switch_o),
    .adc_reset_n_o  (adc_reset_n_o),
    .hi_phase_o     (hi_phase_o),
    .result_o       (result_o),
    .result_valid_o (result_valid_o)
  );

  ////////////////////////////////////////////////////////////
  // check helpers

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp)
    else
    begin
      value_errs++;
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timeout_errs++;
    abort = 1'b1;
    $display("pattern %0d: timed out waiting for %s", pat_idx, what);
  endtask

  // protect state, as after reset
  task automatic check_idle(input string name);
    check_value({name, " adc_reset_n"}, 32'd0, 32'(adc_reset_n_o));
    check_value({name, " sw_pc"}, 32'(SW_PC_BOOT), 32'(switch_o.sw_pc));
    check_value({name, " result_valid"}, 32'd0, 32'(result_valid_o));
  endtask

  ////////////////////////////////////////////////////////////
  // monitor, sampled on the falling edge

  always @(negedge clk)
  begin
    cyc++;
    if (switch_o !== last_switch)
    begin
      last_switch = switch_o;
      last_change_cyc = cyc;
    end
    // release comes precharge_count+2 cycles after the last switch move
    if (monitor_on && adc_reset_n_o && !prev_adc_rst)
      check_value($sformatf("pattern %0d adc release delay", pat_idx),
                  32'(cur_cfg.precharge_count) + 32'd2, 32'(cyc - last_change_cyc));
    if (monitor_on && adc_reset_n_o)
    begin
      check_value($sformatf("pattern %0d azmux", pat_idx),
                  32'(meas_hi ? cur_cfg.azmux_hi : cur_cfg.azmux_lo), 32'(switch_o.azmux));
      check_value($sformatf("pattern %0d sw_pc", pat_idx),
                  32'(meas_hi ? cur_cfg.pc_hi : SW_PC_BOOT), 32'(switch_o.sw_pc));
    end
    prev_adc_rst = adc_reset_n_o;
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  task automatic apply_reset(input az_cfg_t cfg);
    @(posedge clk);
    reset_n     <= 1'b0;
    cfg_i       <= cfg;
    adc_valid_i <= 1'b0;
    adc_count_i <= '0;
    repeat (9)
    begin
      @(posedge clk);
      @(negedge clk);
      check_idle($sformatf("pattern %0d reset", pat_idx));
    end
    // 10th reset cycle, released on this edge
    @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_idle($sformatf("pattern %0d reset", pat_idx));
    @(negedge clk);
    check_idle($sformatf("pattern %0d after reset", pat_idx));
  endtask

  // ADC model, returns on the negedge after the adc reset falls
  task automatic convert_once(input logic [ADC_W-1:0] hi_cnt,
                              input logic [ADC_W-1:0] lo_cnt, output bit ok);
    int                 t;
    int                 delay;
    logic [AZMUX_W-1:0] mux_seen;
    ok = 1'b0;
    // valid of the previous conversion ends here
    @(posedge clk);
    adc_valid_i <= 1'b0;
    t = 0;
    do
    begin
      @(negedge clk);
      t++;
    end
    while (!adc_reset_n_o && t < WAIT_LIMIT);
    if (!adc_reset_n_o)
      report_timeout("the ADC reset to be released");
    else
    begin
      mux_seen = switch_o.azmux;
      delay = 3 + int'($urandom % 18);
      repeat (delay) @(posedge clk);
      adc_valid_i <= 1'b1;
      adc_count_i <= (mux_seen == cur_cfg.azmux_hi) ? hi_cnt : lo_cnt;
      t = 0;
      do
      begin
        @(negedge clk);
        t++;
      end
      while (adc_reset_n_o && t < WAIT_LIMIT);
      if (adc_reset_n_o)
        report_timeout("the ADC reset to fall after valid");
      else
        ok = 1'b1;
    end
  endtask

  task automatic run_pattern(input int base);
    logic [ADC_W-1:0]  hi_cnt;
    logic [ADC_W-1:0]  lo_cnt;
    logic [DIFF_W-1:0] exp_diff;
    az_cfg_t           cfg;
    bit                ok;
    int                t;
    string             tag;
    pat_idx             = int'(pat_mem[base]);
    cfg.precharge_count = pat_mem[base+1][COUNT_W-1:0];
    cfg.azmux_hi        = pat_mem[base+2][AZMUX_W-1:0];
    cfg.azmux_lo        = pat_mem[base+3][AZMUX_W-1:0];
    cfg.pc_hi           = pat_mem[base+4][PC_W-1:0];
    hi_cnt              = pat_mem[base+5][ADC_W-1:0];
    lo_cnt              = pat_mem[base+6][ADC_W-1:0];
    exp_diff            = pat_mem[base+7][DIFF_W-1:0];
    cur_cfg = cfg;
    apply_reset(cfg);
    monitor_on = 1'b1;
    ok = 1'b1;
    for (int k = 0; k < PAIRS && ok; k++)
    begin
      tag = $sformatf("pattern %0d pair %0d", pat_idx, k);
      meas_hi = 1'b1;
      convert_once(hi_cnt, lo_cnt, ok);
      if (ok)
      begin
        check_value({tag, " hi_phase after HI"}, 32'd1, 32'(hi_phase_o));
        // a HI capture alone never completes a pair
        check_value({tag, " result_valid after HI"}, 32'd0, 32'(result_valid_o));
        meas_hi = 1'b0;
        convert_once(hi_cnt, lo_cnt, ok);
      end
      if (ok)
      begin
        t = 0;
        while (!result_valid_o && t < WAIT_LIMIT)
        begin
          @(negedge clk);
          t++;
        end
        ok = result_valid_o;
        if (!ok)
          report_timeout("result_valid");
      end
      if (ok)
      begin
        check_value({tag, " hi_count"}, 32'(hi_cnt), 32'(result_o.hi_count));
        check_value({tag, " lo_count"}, 32'(lo_cnt), 32'(result_o.lo_count));
        check_value({tag, " diff"}, {7'd0, exp_diff}, {7'd0, result_o.diff});
        check_value({tag, " hi_phase after LO"}, 32'd0, 32'(hi_phase_o));
      end
    end
    monitor_on = 1'b0;
  endtask

  initial
  begin
    int p;
    int base;
    int prop_errs;
    bit stop;
    reset_n     = 1'b0;
    cfg_i       = '0;
    adc_valid_i = 1'b0;
    adc_count_i = '0;
    void'($urandom(36878));
    $readmemh("test/azero_patterns.txt", pat_mem);
    p = 0;
    stop = 1'b0;
    while (!stop && !abort && p < MAX_PAT)
    begin
      base = p * PAT_WORDS;
      if (pat_mem[base] === END_MARK)
        stop = 1'b1;
      else if (pat_mem[base] !== 32'(p))
      begin
        other_errs++;
        stop = 1'b1;
        $display("pattern file line %0d has the wrong index %0h", p, pat_mem[base]);
      end
      else
      begin
        run_pattern(base);
        p++;
      end
    end
    if (p == 0)
    begin
      other_errs++;
      $display("no pattern was run, the pattern file is empty or missing");
    end
    prop_errs = int'(i_dut.i_seq.i_props.fail_count);
    $display("%0d patterns: %0d value errors, %0d timeouts, %0d other errors, %0d %s",
             p, value_errs, timeout_errs, other_errs, prop_errs, "property errors");
    if (value_errs + timeout_errs + other_errs + prop_errs == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

//--- verilog.f
source/azero_pkg.sv
source/phase_timer.sv
source/az_result_unit.sv
source/az_sequencer.sv
source/azero_top.sv
test/azero_props.sv
test/azero_tb.sv
